// ==== rtl/ifetch_pkg.sv ====
package ifetch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Byte address width, the bus carries bits [ADDR_WIDTH-1:2]
    localparam int ADDR_WIDTH = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction ROM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int ROM_WORDS       = 24;
    localparam int ROM_INDEX_WIDTH = $clog2(ROM_WORDS);

    localparam string ROM_FILE = "rom.hex";

    // Minimum wait before ack; the ROM adds adr[3:2] on top
    localparam int WAIT_BASE = 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Aligner
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Halfword slots, room for two words plus a held half
    localparam int QUEUE_HALFWORDS = 6;

    typedef enum logic {
        align_idle,
        align_run
    } align_state_t;

endpackage

// ==== rtl/wb_fetch_master.sv ====
`timescale 1ns/1ps

module wb_fetch_master import ifetch_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  logic [ADDR_WIDTH-1:0] start_pc,
    input  logic                  word_space,
    input  logic                  ack,
    input  logic [31:0]           dat_r,
    output logic [ADDR_WIDTH-1:2] adr,
    output logic [31:0]           dat_w,
    output logic [3:0]            sel,
    output logic                  cyc,
    output logic                  stb,
    output logic                  we,
    output logic                  word_valid,
    output logic [31:0]           word_data
);

    logic [ADDR_WIDTH-1:2] next_adr;
    logic                  active;
    logic                  discard;
    logic                  issue;

    // Read-only bus, full word every time
    assign dat_w = '0;
    assign sel   = 4'hf;
    assign we    = 1'b0;

    // Next read waits until the previous word has been pushed into the aligner,
    // so word_space already counts it
    assign issue = active && !cyc && !word_valid && word_space;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus cycle control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (reset) begin
            cyc        <= 1'b0;
            stb        <= 1'b0;
            active     <= 1'b0;
            discard    <= 1'b0;
            word_valid <= 1'b0;
            next_adr   <= '0;
        end else begin
            word_valid <= 1'b0;
            if (start) begin
                active   <= 1'b1;
                next_adr <= start_pc[ADDR_WIDTH-1:2];
                if (cyc && !ack) begin
                    // Access in flight, let it finish and drop its word
                    discard <= 1'b1;
                end else if (cyc) begin
                    // Ack on the start edge, word is simply not forwarded
                    cyc     <= 1'b0;
                    stb     <= 1'b0;
                    discard <= 1'b0;
                end else begin
                    cyc      <= 1'b1;
                    stb      <= 1'b1;
                    adr      <= start_pc[ADDR_WIDTH-1:2];
                    next_adr <= start_pc[ADDR_WIDTH-1:2] + 1'b1;
                end
            end else if (cyc) begin
                if (ack) begin
                    cyc        <= 1'b0;
                    stb        <= 1'b0;
                    discard    <= 1'b0;
                    word_valid <= !discard;
                end
            end else if (issue) begin
                cyc      <= 1'b1;
                stb      <= 1'b1;
                adr      <= next_adr;
                next_adr <= next_adr + 1'b1;
            end
        end
    end

    // Returned word, valid together with word_valid
    always_ff @(posedge clock) begin
        if (cyc && ack) begin
            word_data <= dat_r;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone classic rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    stb_within_cyc: assert property (
        @(posedge clock) disable iff (reset)
        stb |-> cyc
    );

    // Address and strobe held until the slave acks
    adr_held_until_ack: assert property (
        @(posedge clock) disable iff (reset)
        (stb && !ack) |=> (stb && $stable(adr))
    );

endmodule

// ==== rtl/rvc_aligner.sv ====
`timescale 1ns/1ps

module rvc_aligner import ifetch_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  logic [ADDR_WIDTH-1:0] start_pc,
    input  logic                  word_valid,
    input  logic [31:0]           word_data,
    input  logic                  instr_ready,
    output logic                  word_space,
    output logic                  instr_valid,
    output logic [31:0]           instr,
    output logic [ADDR_WIDTH-1:0] instr_pc,
    output logic                  instr_compressed
);

    typedef logic [$clog2(QUEUE_HALFWORDS)-1:0]   qptr_t;
    typedef logic [$clog2(QUEUE_HALFWORDS+1)-1:0] qcount_t;

    align_state_t          state;
    logic [15:0]           queue [QUEUE_HALFWORDS];
    qptr_t                 rd_ptr;
    qptr_t                 wr_ptr;
    qcount_t               count;
    qcount_t               free_slots;
    qcount_t               push_n;
    qcount_t               pop_n;
    logic                  skip_low;
    logic [ADDR_WIDTH-1:0] pc;
    logic [15:0]           head_lo;
    logic [15:0]           head_hi;
    logic                  head_compressed;
    logic                  head_ready;
    logic                  push;
    logic                  take;

    // Circular pointer step for a depth that is not a power of two
    function automatic qptr_t ptr_add(input qptr_t p, input int unsigned n);
        int unsigned sum;
        sum = p + n;
        if (sum >= QUEUE_HALFWORDS) begin
            sum = sum - QUEUE_HALFWORDS;
        end
        return qptr_t'(sum);
    endfunction

    assign head_lo         = queue[rd_ptr];
    assign head_hi         = queue[ptr_add(rd_ptr, 1)];
    assign head_compressed = head_lo[1:0] != 2'b11;
    assign head_ready      = (count >= 2) || (count == 1 && head_compressed);

    assign free_slots = qcount_t'(QUEUE_HALFWORDS) - count;
    assign word_space = free_slots >= 2;

    assign push = (state == align_run) && word_valid;
    assign take = (state == align_run) && (!instr_valid || instr_ready) && head_ready;

    always_comb begin
        push_n = '0;
        pop_n  = '0;
        if (push) begin
            push_n = skip_low ? qcount_t'(1) : qcount_t'(2);
        end
        if (take) begin
            pop_n = head_compressed ? qcount_t'(1) : qcount_t'(2);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Queue and output control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= align_idle;
            rd_ptr      <= '0;
            wr_ptr      <= '0;
            count       <= '0;
            skip_low    <= 1'b0;
            instr_valid <= 1'b0;
        end else if (start) begin
            state       <= align_run;
            rd_ptr      <= '0;
            wr_ptr      <= '0;
            count       <= '0;
            skip_low    <= start_pc[1];
            instr_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr   <= ptr_add(wr_ptr, push_n);
                skip_low <= 1'b0;
            end
            if (take) begin
                rd_ptr      <= ptr_add(rd_ptr, pop_n);
                instr_valid <= 1'b1;
            end else if (instr_ready) begin
                instr_valid <= 1'b0;
            end
            count <= count + push_n - pop_n;
        end
    end

    always_ff @(posedge clock) begin
        if (!start && push) begin
            if (skip_low) begin
                // Start pc in the upper half skips the low half
                queue[wr_ptr] <= word_data[31:16];
            end else begin
                queue[wr_ptr]             <= word_data[15:0];
                queue[ptr_add(wr_ptr, 1)] <= word_data[31:16];
            end
        end
        if (start) begin
            pc <= start_pc;
        end else if (take) begin
            pc               <= pc + (head_compressed ? ADDR_WIDTH'(2) : ADDR_WIDTH'(4));
            instr_pc         <= pc;
            instr            <= head_compressed ? {16'h0000, head_lo} : {head_hi, head_lo};
            instr_compressed <= head_compressed;
        end
    end

    // Master only fetches when word_space allowed it
    no_queue_overflow: assert property (
        @(posedge clock) disable iff (reset)
        (push && !start) |-> (free_slots >= push_n)
    );

endmodule

// ==== rtl/wb_inst_rom.sv ====
`timescale 1ns/1ps

module wb_inst_rom import ifetch_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:2] adr,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [3:0]            sel,
    input  logic [31:0]           dat_w,
    output logic [31:0]           dat_r,
    output logic                  ack
);

    logic [31:0]                mem [ROM_WORDS];
    logic [ROM_INDEX_WIDTH-1:0] index;
    logic [2:0]                 wait_cycles;
    logic [2:0]                 wait_count;
    logic                       busy;
    logic                       ack_due;

    initial begin
        $readmemh(ROM_FILE, mem);
    end

    // Index wraps at the ROM end
    assign index = ROM_INDEX_WIDTH'(adr % ROM_WORDS);

    // Wait grows with the word offset within each group of four
    assign wait_cycles = 3'(WAIT_BASE) + {1'b0, adr[3:2]};
    assign ack_due     = busy && (wait_count >= wait_cycles);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy       <= 1'b0;
            wait_count <= '0;
            ack        <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (!cyc) begin
                busy <= 1'b0;
            end else if (stb && !busy && !ack) begin
                busy       <= 1'b1;
                wait_count <= 3'd1;
            end else if (ack_due) begin
                ack  <= 1'b1;
                busy <= 1'b0;
            end else if (busy) begin
                wait_count <= wait_count + 3'd1;
            end
        end
    end

    // Writes are acked but leave the data alone
    always_ff @(posedge clock) begin
        if (ack_due && !we) begin
            dat_r <= mem[index];
        end
    end

endmodule

// ==== rtl/ibus_halfword_probe.sv ====
`timescale 1ns/1ps

module ibus_halfword_probe import ifetch_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] watch_addr,
    input  logic [ADDR_WIDTH-1:2] adr,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [3:0]            sel,
    input  logic                  ack,
    input  logic [31:0]           dat_r,
    output logic                  probe_valid,
    output logic [15:0]           probe_data
);

    logic hit;

    // Acknowledged read of the word holding the watched halfword
    assign hit = cyc && stb && ack && !we && (adr == watch_addr[ADDR_WIDTH-1:2]);

    always_ff @(posedge clock) begin
        if (reset) begin
            probe_valid <= 1'b0;
        end else begin
            probe_valid <= hit;
        end
    end

    always_ff @(posedge clock) begin
        if (hit) begin
            probe_data <= watch_addr[1] ? dat_r[31:16] : dat_r[15:0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction bus rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    ibus_never_writes: assert property (
        @(posedge clock) disable iff (reset)
        (cyc && stb) |-> !we
    );

    ibus_full_word: assert property (
        @(posedge clock) disable iff (reset)
        (cyc && stb) |-> (sel == 4'hf)
    );

endmodule

// ==== rtl/ifetch_top.sv ====
`timescale 1ns/1ps

module ifetch_top import ifetch_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  logic [ADDR_WIDTH-1:0] start_pc,
    input  logic                  instr_ready,
    input  logic [ADDR_WIDTH-1:0] watch_addr,
    output logic                  instr_valid,
    output logic [31:0]           instr,
    output logic [ADDR_WIDTH-1:0] instr_pc,
    output logic                  instr_compressed,
    output logic                  probe_valid,
    output logic [15:0]           probe_data
);

    // Instruction bus
    logic [ADDR_WIDTH-1:2] adr;
    logic [31:0]           dat_w;
    logic [31:0]           dat_r;
    logic [3:0]            sel;
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic                  ack;

    // Master to aligner
    logic                  word_valid;
    logic [31:0]           word_data;
    logic                  word_space;

    wb_fetch_master u_master (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .start_pc   (start_pc),
        .word_space (word_space),
        .ack        (ack),
        .dat_r      (dat_r),
        .adr        (adr),
        .dat_w      (dat_w),
        .sel        (sel),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .word_valid (word_valid),
        .word_data  (word_data)
    );

    wb_inst_rom u_rom (
        .clock (clock),
        .reset (reset),
        .adr   (adr),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .sel   (sel),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    rvc_aligner u_aligner (
        .clock            (clock),
        .reset            (reset),
        .start            (start),
        .start_pc         (start_pc),
        .word_valid       (word_valid),
        .word_data        (word_data),
        .instr_ready      (instr_ready),
        .word_space       (word_space),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .instr_pc         (instr_pc),
        .instr_compressed (instr_compressed)
    );

    ibus_halfword_probe u_probe (
        .clock       (clock),
        .reset       (reset),
        .watch_addr  (watch_addr),
        .adr         (adr),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .sel         (sel),
        .ack         (ack),
        .dat_r       (dat_r),
        .probe_valid (probe_valid),
        .probe_data  (probe_data)
    );

endmodule

// ==== testbench/tb_ifetch.sv ====
`timescale 1ns/1ps

module tb_ifetch import ifetch_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int RUN_COUNT      = 6;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] start_pc;
        logic [ADDR_WIDTH-1:0] watch_addr;
        logic [15:0]           count;
        logic                  backpressure;
    } run_entry_t;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  start;
    logic [ADDR_WIDTH-1:0] start_pc;
    logic                  instr_ready;
    logic [ADDR_WIDTH-1:0] watch_addr;
    logic                  instr_valid;
    logic [31:0]           instr;
    logic [ADDR_WIDTH-1:0] instr_pc;
    logic                  instr_compressed;
    logic                  probe_valid;
    logic [15:0]           probe_data;

    logic [31:0] rom_model [ROM_WORDS];
    run_entry_t  runs [RUN_COUNT];
    logic [31:0] lfsr;
    int          probe_pulses;

    always #4 clock = ~clock;

    ifetch_top dut (
        .clock            (clock),
        .reset            (reset),
        .start            (start),
        .start_pc         (start_pc),
        .instr_ready      (instr_ready),
        .watch_addr       (watch_addr),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .instr_pc         (instr_pc),
        .instr_compressed (instr_compressed),
        .probe_valid      (probe_valid),
        .probe_data       (probe_data)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // The ROM image repeats every ROM_WORDS words
    function automatic logic [15:0] model_half(input logic [ADDR_WIDTH-1:0] addr);
        int          index;
        logic [31:0] word;
        index = int'((addr >> 2) % ROM_WORDS);
        word  = rom_model[index];
        return addr[1] ? word[31:16] : word[15:0];
    endfunction

    // Low bits 11 open a 32-bit instruction, anything else is compressed
    task automatic predict_next(inout logic [ADDR_WIDTH-1:0] pc,
                                output logic [31:0] exp_instr,
                                output logic exp_compressed);
        logic [15:0] low;
        low            = model_half(pc);
        exp_compressed = low[1:0] != 2'b11;
        if (exp_compressed) begin
            exp_instr = {16'h0000, low};
            pc        = pc + 2;
        end else begin
            exp_instr = {model_half(pc + 2), low};
            pc        = pc + 4;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking and driving
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    // Inputs move 1 ns after the edge, outputs are read at the falling edge
    task automatic run_cycle(input logic pulse, input logic backpressure,
                             input logic [ADDR_WIDTH-1:0] pc_in,
                             input logic [ADDR_WIDTH-1:0] watch_in);
        logic [ADDR_WIDTH-1:0] watch_seen;
        @(posedge clock);
        watch_seen = watch_addr;
        #1;
        start = pulse;
        if (pulse) begin
            start_pc    = pc_in;
            watch_addr  = watch_in;
            instr_ready = 1'b0;
        end else if (backpressure) begin
            instr_ready = lfsr[0];
            lfsr        = lfsr_step(lfsr);
        end else begin
            instr_ready = 1'b1;
        end
        @(negedge clock);
        if (probe_valid) begin
            probe_pulses++;
            check_value("probe_data", 32'(probe_data), 32'(model_half(watch_seen)));
        end
    endtask

    initial begin
        logic [ADDR_WIDTH-1:0] exp_pc;
        logic [ADDR_WIDTH-1:0] pc_now;
        logic [31:0]           exp_instr;
        logic                  exp_compressed;
        int                    waited;
        bit                    taken;

        reset        = 1'b1;
        start        = 1'b0;
        start_pc     = '0;
        instr_ready  = 1'b0;
        watch_addr   = '0;
        lfsr         = 32'hd5f0f9c1;
        probe_pulses = 0;
        $readmemh(ROM_FILE, rom_model);

        // start_pc, watch_addr, instructions, back-pressure
        runs[0] = '{32'h0000_0000, 32'h0000_0006, 16'd20, 1'b0};
        runs[1] = '{32'h0000_0006, 32'h0000_0010, 16'd16, 1'b0};
        runs[2] = '{32'h0000_0022, 32'h0000_002e, 16'd40, 1'b1};
        runs[3] = '{32'h0000_003e, 32'h0000_0040, 16'd10, 1'b1};
        runs[4] = '{32'h0000_005e, 32'h0000_0062, 16'd8,  1'b0};
        runs[5] = '{32'h0000_0014, 32'h0000_0014, 16'd30, 1'b1};

        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        // Nothing may come out before the first start
        repeat (20) begin
            run_cycle(1'b0, 1'b0, '0, '0);
            check_value("instr_valid", 32'(instr_valid), 32'd0);
            check_value("probe_valid", 32'(probe_valid), 32'd0);
        end

        // Every start after the first one abandons a running stream
        for (int e = 0; e < RUN_COUNT; e++) begin
            run_cycle(1'b1, 1'b0, runs[e].start_pc, runs[e].watch_addr);
            probe_pulses = 0;
            exp_pc       = runs[e].start_pc;
            for (int k = 0; k < int'(runs[e].count); k++) begin
                waited = 0;
                taken  = 1'b0;
                while (!taken) begin
                    run_cycle(1'b0, runs[e].backpressure, '0, '0);
                    if (instr_valid && instr_ready) begin
                        taken  = 1'b1;
                        pc_now = exp_pc;
                        predict_next(exp_pc, exp_instr, exp_compressed);
                        check_value("instr_pc", instr_pc, pc_now);
                        check_value("instr", instr, exp_instr);
                        check_value("instr_compressed", 32'(instr_compressed),
                                    32'(exp_compressed));
                    end else begin
                        waited++;
                        if (waited >= TIMEOUT_CYCLES) begin
                            $display("Timeout at %0t: instruction %0d of run %0d never arrived",
                                     $time, k, e);
                            stop_with_failure();
                        end
                    end
                end
            end
            if (probe_pulses == 0) begin
                $display("Run %0d: the probe never reported the halfword at 0x%h",
                         e, runs[e].watch_addr);
                stop_with_failure();
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/ifetch_pkg.sv
rtl/wb_fetch_master.sv
rtl/rvc_aligner.sv
rtl/wb_inst_rom.sv
rtl/ibus_halfword_probe.sv
rtl/ifetch_top.sv
testbench/tb_ifetch.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the fetch testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ifetch -f tb.f -o sim_ifetch \
    && ./obj_dir/sim_ifetch | tee sim.log
grep -qx '\*\*\* PASSED \*\*\*' sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== rom.hex ====
// One 32-bit ROM word per line, word 0 first, upper halfword on the left
00a00093
05134501
80820010
00b50533
0613c605
47810030
0ff0000f
00730505
91010000
fe0718e3
853e852a
02a58593
06934681
00810006
00c58633
0737e022
65050001
40b50533
00ef4585
01410080
00452283
0113c0de
8082ff01
06934501
